//--- build.f
source/board_pkg.sv
source/key_bus_if.sv
source/key_sampler.sv
source/key_filter.sv
source/key_panel.sv
source/uart_rx.sv
source/uart_tx.sv
source/seg_scan.sv
source/board_top.sv
test/board_top_asserts.sv
test/board_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and search the output for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps -f build.f \
	--top-module board_top_tb -o board_top_sim \
	&& ./obj_dir/board_top_sim | tee /dev/stderr | grep -qF 'All tests passed!' \
	&& echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- source/board_pkg.sv
// shared definitions for the front-panel design
// state encodings, seven-segment font and default top-level parameter values
`default_nettype none

package board_pkg;

	// number of push keys on the panel
	localparam int unsigned key_count = 4;

	// defaults for a 50 MHz board clock
	localparam int unsigned default_clk_hz           = 50_000_000;
	localparam int unsigned default_baud_rate        = 115_200;
	// 5 ms key sample period
	localparam int unsigned default_sample_div       = 250_000;
	// 4 stable samples, about 20 ms
	localparam int unsigned default_debounce_samples = 4;
	// 1 ms per digit
	localparam int unsigned default_scan_div         = 50_000;
	// 100 ms beep
	localparam int unsigned default_beep_cycles      = 5_000_000;

	// receiver states
	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} uart_rx_state_e;

	// transmitter states
	typedef enum logic [1:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_stop
	} uart_tx_state_e;

	// common anode, active low, bit order dp g f e d c b a
	localparam logic [7:0] seg_font [0:15] = '{
		8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
		8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e
	};

	// every segment and the point off
	localparam logic [7:0] seg_blank = 8'hff;

endpackage

`default_nettype wire

//--- source/board_top.sv
// front-panel top level: keys, buzzer, MCU UART, LEDs and the seven-segment display
// all timing parameters are set here and passed down to the blocks
`timescale 1ns/10ps
`default_nettype none

module board_top #(
	parameter int unsigned clk_hz           = board_pkg::default_clk_hz,
	parameter int unsigned baud_rate        = board_pkg::default_baud_rate,
	parameter int unsigned sample_div       = board_pkg::default_sample_div,
	parameter int unsigned debounce_samples = board_pkg::default_debounce_samples,
	parameter int unsigned scan_div         = board_pkg::default_scan_div,
	parameter int unsigned beep_cycles      = board_pkg::default_beep_cycles
) (
	input wire                             sys_clk,
	input wire                             sys_rst_n,
	// push keys, low when pressed
	input wire [board_pkg::key_count-1:0] key_in,
	// uart to and from the MCU
	input wire                             uart_rx_port,
	output logic                           uart_tx_port,
	output logic [7:0]                     led,
	// buzzer, active high
	output logic                           bepeer,
	// display segments and digit anodes, both active low
	output logic [7:0]                     seg_number,
	output logic [7:0]                     seg_choice
);

	logic [7:0] rx_byte;
	logic       rx_valid;
	logic [7:0] tx_byte;
	logic       tx_start;
	logic       tx_busy;
	// last byte sent, for the display
	logic [7:0] last_tx;

	key_bus_if key_bus ();

	key_sampler #(
		.sample_div (sample_div)
	) ins_key_sampler (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_in    (key_in),
		.bus       (key_bus)
	);

	// one debounce filter per key
	for (genvar i = 0; i < board_pkg::key_count; i++) begin : gen_filter
		key_filter #(
			.debounce_samples (debounce_samples),
			.index            (i)
		) ins_key_filter (
			.sys_clk   (sys_clk),
			.sys_rst_n (sys_rst_n),
			.bus       (key_bus)
		);
	end

	key_panel #(
		.beep_cycles (beep_cycles)
	) ins_key_panel (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.bus       (key_bus),
		.tx_busy   (tx_busy),
		.tx_start  (tx_start),
		.tx_byte   (tx_byte),
		.bepeer    (bepeer)
	);

	uart_rx #(
		.clk_hz    (clk_hz),
		.baud_rate (baud_rate)
	) ins_uart_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.rx_byte      (rx_byte),
		.rx_valid     (rx_valid)
	);

	uart_tx #(
		.clk_hz    (clk_hz),
		.baud_rate (baud_rate)
	) ins_uart_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_start     (tx_start),
		.tx_byte      (tx_byte),
		.uart_tx_port (uart_tx_port),
		.tx_busy      (tx_busy)
	);

	// led holds the last good byte from the MCU
	// last_tx follows every accepted key byte
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			led     <= '0;
			last_tx <= '0;
		end else begin
			if (rx_valid) begin
				led <= rx_byte;
			end
			if (tx_start) begin
				last_tx <= tx_byte;
			end
		end
	end

	seg_scan #(
		.scan_div (scan_div)
	) ins_seg_scan (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.rx_byte    (led),
		.tx_byte    (last_tx),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

`default_nettype wire

//--- source/key_bus_if.sv
// key path bundle between the sampler, the debounce filters and the panel logic
// one sampler drives tick and raw, each filter owns one bit of level and press
`timescale 1ns/10ps
`default_nettype none

interface key_bus_if;

	// one-cycle strobe every sample period
	logic                             tick;
	// synchronized keys, 1 = pressed
	logic [board_pkg::key_count-1:0] raw;
	// debounced pressed state
	logic [board_pkg::key_count-1:0] level;
	// one-cycle pulse on a rising level
	logic [board_pkg::key_count-1:0] press;

	modport sampler (output tick, output raw);
	modport filter  (input tick, input raw, output level, output press);
	modport panel   (input level, input press);

endinterface

`default_nettype wire

//--- source/key_filter.sv
// debounce filter for one key, instantiated once per key index
// level follows raw only after debounce_samples disagreeing ticks in a row
`timescale 1ns/10ps
`default_nettype none

module key_filter #(
	parameter int unsigned debounce_samples = board_pkg::default_debounce_samples,
	parameter int unsigned index            = 0
) (
	input wire        sys_clk,
	input wire        sys_rst_n,
	key_bus_if.filter bus
);

	// consecutive disagreeing samples so far
	logic [31:0] diff_cnt;
	logic        level_q;
	logic        press_q;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			diff_cnt <= '0;
			level_q  <= 1'b0;
			press_q  <= 1'b0;
		end else begin
			press_q <= 1'b0;
			if (bus.tick) begin
				if (bus.raw[index] == level_q) begin
					// agreement restarts the count
					diff_cnt <= '0;
				end else if (diff_cnt == debounce_samples - 1) begin
					// enough samples, take the new state
					diff_cnt <= '0;
					level_q  <= ~level_q;
					press_q  <= ~level_q;
				end else begin
					diff_cnt <= diff_cnt + 32'd1;
				end
			end
		end
	end

	// each filter owns its own bit
	assign bus.level[index] = level_q;
	assign bus.press[index] = press_q;

endmodule

`default_nettype wire

//--- source/key_panel.sv
// turns debounced key presses into a transmit request and a buzzer gate
// lowest pressed index wins, presses during a busy transmitter are dropped
`timescale 1ns/10ps
`default_nettype none

module key_panel #(
	parameter int unsigned beep_cycles = board_pkg::default_beep_cycles
) (
	input wire        sys_clk,
	input wire        sys_rst_n,
	key_bus_if.panel  bus,
	input wire        tx_busy,
	output logic       tx_start,
	output logic [7:0] tx_byte,
	output logic       bepeer
);

	localparam int unsigned idx_w = $clog2(board_pkg::key_count);

	// pressed this cycle and still held
	logic [board_pkg::key_count-1:0] hit;
	logic [idx_w-1:0]                 sel_idx;
	logic [31:0]                      beep_cnt;

	assign hit = bus.press & bus.level;

	// priority pick, scan downward so the lowest set bit is kept
	always_comb begin
		sel_idx = '0;
		for (int i = board_pkg::key_count - 1; i >= 0; i--) begin
			if (hit[i]) begin
				sel_idx = idx_w'(i);
			end
		end
	end

	// start strobe one clock after press
	// also skip the cycle where our own start is still in flight
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_start <= 1'b0;
		end else begin
			tx_start <= (|hit) && !tx_busy && !tx_start;
		end
	end

	// ascii digit, 0x30 plus key index
	always_ff @(posedge sys_clk) begin
		if ((|hit) && !tx_busy && !tx_start) begin
			tx_byte <= 8'(8'h30 + sel_idx);
		end
	end

	// buzzer gate, reloaded by every press
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			beep_cnt <= '0;
		end else if (|hit) begin
			beep_cnt <= beep_cycles;
		end else if (beep_cnt != 0) begin
			beep_cnt <= beep_cnt - 32'd1;
		end
	end

	assign bepeer = (beep_cnt != 0);

endmodule

`default_nettype wire

//--- source/key_sampler.sv
// key front end: two-flop synchronizer for the active-low keys and the
// sample tick divider shared by all debounce filters
`timescale 1ns/10ps
`default_nettype none

module key_sampler #(
	parameter int unsigned sample_div = board_pkg::default_sample_div
) (
	input wire                             sys_clk,
	input wire                             sys_rst_n,
	input wire [board_pkg::key_count-1:0] key_in,
	key_bus_if.sampler                     bus
);

	// first sync stage, still active low
	logic [board_pkg::key_count-1:0] key_meta;
	logic [31:0]                      div_cnt;

	// second stage inverts so raw reads 1 while pressed
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_meta <= '1;
			bus.raw  <= '0;
		end else begin
			key_meta <= key_in;
			bus.raw  <= ~key_meta;
		end
	end

	// tick once every sample_div clocks
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			div_cnt  <= '0;
			bus.tick <= 1'b0;
		end else if (div_cnt == sample_div - 1) begin
			div_cnt  <= '0;
			bus.tick <= 1'b1;
		end else begin
			div_cnt  <= div_cnt + 32'd1;
			bus.tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- source/seg_scan.sv
// eight-digit common-anode display scanner
// digit 7 shows F, digits 4..3 the tx byte, digits 1..0 the rx byte, others blank
`timescale 1ns/10ps
`default_nettype none

module seg_scan #(
	parameter int unsigned scan_div = board_pkg::default_scan_div
) (
	input wire         sys_clk,
	input wire         sys_rst_n,
	input wire  [7:0]  rx_byte,
	input wire  [7:0]  tx_byte,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice
);

	logic [31:0] div_cnt;
	logic [2:0]  digit;
	// nibble for the current digit and whether it is lit
	logic [3:0]  nibble;
	logic        lit;

	// step the digit index every scan_div clocks
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			div_cnt <= '0;
			digit   <= '0;
		end else if (div_cnt == scan_div - 1) begin
			div_cnt <= '0;
			digit   <= digit + 3'd1;
		end else begin
			div_cnt <= div_cnt + 32'd1;
		end
	end

	// digit content
	always_comb begin
		nibble = 4'hf;
		lit    = 1'b1;
		case (digit)
			3'd7: nibble = 4'hf;
			3'd4: nibble = tx_byte[7:4];
			3'd3: nibble = tx_byte[3:0];
			3'd1: nibble = rx_byte[7:4];
			3'd0: nibble = rx_byte[3:0];
			default: lit = 1'b0;
		endcase
	end

	// select and pattern change together
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			seg_choice <= 8'hfe;
			seg_number <= board_pkg::seg_blank;
		end else begin
			// one anode low at a time
			seg_choice <= ~(8'h01 << digit);
			seg_number <= lit ? board_pkg::seg_font[nibble] : board_pkg::seg_blank;
		end
	end

endmodule

`default_nettype wire

//--- source/uart_rx.sv
// 8N1 UART receiver for bytes coming from the MCU, line idles high
// samples every bit at mid-period, a low stop bit drops the byte
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
	parameter int unsigned clk_hz    = board_pkg::default_clk_hz,
	parameter int unsigned baud_rate = board_pkg::default_baud_rate
) (
	input wire         sys_clk,
	input wire         sys_rst_n,
	input wire         uart_rx_port,
	output logic [7:0] rx_byte,
	output logic       rx_valid
);

	localparam int unsigned bit_cycles  = clk_hz / baud_rate;
	localparam int unsigned half_cycles = bit_cycles / 2;

	logic                       rx_meta;
	logic                       rx_sync;
	board_pkg::uart_rx_state_e state;
	// clocks left until the next sample point
	logic [31:0]                bit_cnt;
	logic [2:0]                 bit_idx;
	logic [7:0]                 shift_reg;

	// line is asynchronous to us
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= uart_rx_port;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= board_pkg::rx_idle;
			bit_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				board_pkg::rx_idle: begin
					// falling edge, wait half a bit to reach the middle
					if (!rx_sync) begin
						state   <= board_pkg::rx_start;
						bit_cnt <= half_cycles - 1;
					end
				end
				board_pkg::rx_start: begin
					if (bit_cnt != 0) begin
						bit_cnt <= bit_cnt - 32'd1;
					end else if (rx_sync) begin
						// glitch, not a real start bit
						state <= board_pkg::rx_idle;
					end else begin
						state   <= board_pkg::rx_data;
						bit_cnt <= bit_cycles - 1;
						bit_idx <= '0;
					end
				end
				board_pkg::rx_data: begin
					if (bit_cnt != 0) begin
						bit_cnt <= bit_cnt - 32'd1;
					end else begin
						bit_cnt <= bit_cycles - 1;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= board_pkg::rx_stop;
						end
					end
				end
				board_pkg::rx_stop: begin
					if (bit_cnt != 0) begin
						bit_cnt <= bit_cnt - 32'd1;
					end else begin
						// only a high stop bit makes a valid byte
						state    <= board_pkg::rx_idle;
						rx_valid <= rx_sync;
					end
				end
				default: state <= board_pkg::rx_idle;
			endcase
		end
	end

	// lsb first, shift in from the top
	always_ff @(posedge sys_clk) begin
		if (state == board_pkg::rx_data && bit_cnt == 0) begin
			shift_reg <= {rx_sync, shift_reg[7:1]};
		end
	end

	assign rx_byte = shift_reg;

endmodule

`default_nettype wire

//--- source/uart_tx.sv
// 8N1 UART transmitter towards the MCU, line idles high
// a tx_start strobe while idle loads the byte and sends one frame
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
	parameter int unsigned clk_hz    = board_pkg::default_clk_hz,
	parameter int unsigned baud_rate = board_pkg::default_baud_rate
) (
	input wire        sys_clk,
	input wire        sys_rst_n,
	input wire        tx_start,
	input wire  [7:0] tx_byte,
	output logic      uart_tx_port,
	output logic      tx_busy
);

	localparam int unsigned bit_cycles = clk_hz / baud_rate;

	board_pkg::uart_tx_state_e state;
	// clocks left in the current bit
	logic [31:0]                bit_cnt;
	logic [2:0]                 bit_idx;
	logic [7:0]                 shift_reg;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state        <= board_pkg::tx_idle;
			bit_cnt      <= '0;
			bit_idx      <= '0;
			uart_tx_port <= 1'b1;
		end else begin
			case (state)
				board_pkg::tx_idle: begin
					// start bit goes out on the next clock
					if (tx_start) begin
						state        <= board_pkg::tx_start;
						bit_cnt      <= bit_cycles - 1;
						uart_tx_port <= 1'b0;
					end
				end
				board_pkg::tx_start: begin
					if (bit_cnt != 0) begin
						bit_cnt <= bit_cnt - 32'd1;
					end else begin
						state        <= board_pkg::tx_data;
						bit_cnt      <= bit_cycles - 1;
						bit_idx      <= '0;
						uart_tx_port <= shift_reg[0];
					end
				end
				board_pkg::tx_data: begin
					if (bit_cnt != 0) begin
						bit_cnt <= bit_cnt - 32'd1;
					end else begin
						bit_cnt <= bit_cycles - 1;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state        <= board_pkg::tx_stop;
							uart_tx_port <= 1'b1;
						end else begin
							uart_tx_port <= shift_reg[1];
						end
					end
				end
				board_pkg::tx_stop: begin
					// busy drops once the stop bit has run its period
					if (bit_cnt != 0) begin
						bit_cnt <= bit_cnt - 32'd1;
					end else begin
						state <= board_pkg::tx_idle;
					end
				end
				default: state <= board_pkg::tx_idle;
			endcase
		end
	end

	// data byte, lsb leaves first
	always_ff @(posedge sys_clk) begin
		if (state == board_pkg::tx_idle && tx_start) begin
			shift_reg <= tx_byte;
		end else if (state == board_pkg::tx_data && bit_cnt == 0) begin
			shift_reg <= {1'b0, shift_reg[7:1]};
		end
	end

	assign tx_busy = (state != board_pkg::tx_idle);

endmodule

`default_nettype wire

//--- test/board_top_asserts.sv
// concurrent checks on the top-level outputs, bound into board_top
// scan select, reset values and the idle level of the transmit line
`timescale 1ns/10ps
`default_nettype none

module board_top_asserts (
	input wire       sys_clk,
	input wire       sys_rst_n,
	input wire       uart_tx_port,
	input wire       bepeer,
	input wire [7:0] seg_choice,
	input wire [1:0] tx_state
);

	// exactly one anode low
	scan_one_digit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$countones(~seg_choice) == 1)
		else $error("seg_choice 0x%0h does not select a single digit", seg_choice);

	// checked on the falling edge, after reset has reached the flops
	reset_outputs: assert property (@(negedge sys_clk)
		!sys_rst_n |-> (uart_tx_port && !bepeer))
		else $error("uart_tx_port or bepeer not at reset value during reset");

	// idle transmitter keeps the line high
	idle_line_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(tx_state == board_pkg::tx_idle) |-> uart_tx_port)
		else $error("uart_tx_port low while the transmitter is idle");

endmodule

bind board_top board_top_asserts asserts0 (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.uart_tx_port (uart_tx_port),
	.bepeer       (bepeer),
	.seg_choice   (seg_choice),
	.tx_state     (ins_uart_tx.state)
);

`default_nettype wire

//--- test/board_top_tb.sv
// testbench for the front-panel top level
// applies a table of key presses, key bounces and MCU bytes, then decodes one display scan
`timescale 1ns/10ps
`default_nettype none

module board_top_tb;

	// 16 clocks per uart bit
	localparam int unsigned clk_hz     = 1_600_000;
	localparam int unsigned baud_rate  = 100_000;
	localparam int unsigned bit_clocks = clk_hz / baud_rate;
	localparam int unsigned scan_div   = 8;
	localparam int          row_count  = 9;

	localparam logic [1:0] act_press  = 2'd0;
	localparam logic [1:0] act_bounce = 2'd1;
	localparam logic [1:0] act_send   = 2'd2;

	// one stimulus step and what the board shows after it
	typedef struct packed {
		logic [1:0] act;
		logic [1:0] key;
		logic [7:0] data;
		logic [7:0] exp_tx;
		logic [7:0] exp_led;
		logic       exp_beep;
	} row_t;

	logic                             sys_clk;
	logic                             sys_rst_n;
	logic [board_pkg::key_count-1:0] key_in;
	logic                             uart_rx_port;
	logic                             uart_tx_port;
	logic [7:0]                       led;
	logic                             bepeer;
	logic [7:0]                       seg_number;
	logic [7:0]                       seg_choice;

	row_t rows [0:row_count-1];

	board_top #(
		.clk_hz           (clk_hz),
		.baud_rate        (baud_rate),
		.sample_div       (4),
		.debounce_samples (3),
		.scan_div         (scan_div),
		.beep_cycles      (50)
	) dut0 (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.key_in       (key_in),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port),
		.led          (led),
		.bepeer       (bepeer),
		.seg_number   (seg_number),
		.seg_choice   (seg_choice)
	);

	always #20 sys_clk = ~sys_clk;

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Test failures found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("Test failures found");
		$fatal(1, "stopped on timeout");
	endtask

	// line stays idle and the buzzer stays off
	task automatic check_quiet(input int unsigned cycles);
		repeat (cycles) begin
			@(negedge sys_clk);
			check_value("uart_tx_port", 32'(uart_tx_port), 32'd1);
			check_value("bepeer", 32'(bepeer), 32'd0);
		end
	endtask

	// rebuild one frame from uart_tx_port by sampling each bit mid-period
	task automatic monitor_byte(output logic [7:0] b, input logic beep_exp);
		int unsigned n;
		n = 0;
		while (uart_tx_port !== 1'b0) begin
			if (n == 100) fail_timeout("a start bit on uart_tx_port");
			@(negedge sys_clk);
			n++;
		end
		// buzzer runs while the frame goes out
		check_value("bepeer", 32'(bepeer), 32'(beep_exp));
		repeat (bit_clocks / 2) @(negedge sys_clk);
		check_value("uart_tx_port start bit", 32'(uart_tx_port), 32'd0);
		for (int i = 0; i < 8; i++) begin
			repeat (bit_clocks) @(negedge sys_clk);
			b[i] = uart_tx_port;
		end
		repeat (bit_clocks) @(negedge sys_clk);
		check_value("uart_tx_port stop bit", 32'(uart_tx_port), 32'd1);
	endtask

	// hold the key for one byte and release it without a second byte
	task automatic press_key(input logic [1:0] k, input logic [7:0] exp_tx,
			input logic exp_beep);
		logic [7:0] got;
		key_in[k] = 1'b0;
		monitor_byte(got, exp_beep);
		check_value("uart byte", 32'(got), 32'(exp_tx));
		// beep time is far shorter than a frame
		check_value("bepeer", 32'(bepeer), 32'd0);
		check_quiet(40);
		key_in[k] = 1'b1;
		check_quiet(40);
	endtask

	// 5 clocks low covers at most two sample ticks
	task automatic bounce_key(input logic [1:0] k);
		key_in[k] = 1'b0;
		repeat (5) @(negedge sys_clk);
		key_in[k] = 1'b1;
		check_quiet(200);
	endtask

	// MCU side of the link in 8N1 with lsb first
	task automatic send_byte(input logic [7:0] b);
		uart_rx_port = 1'b0;
		repeat (bit_clocks) @(negedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			uart_rx_port = b[i];
			repeat (bit_clocks) @(negedge sys_clk);
		end
		uart_rx_port = 1'b1;
		repeat (bit_clocks) @(negedge sys_clk);
	endtask

	task automatic wait_led(input logic [7:0] expected);
		int unsigned n;
		n = 0;
		while (led !== expected) begin
			if (n == 2 * bit_clocks) fail_timeout("led to show the received byte");
			@(negedge sys_clk);
			n++;
		end
	endtask

	// walk digits 0 to 7 and compare each pattern with the font
	task automatic check_scan(input logic [7:0] tx, input logic [7:0] rx);
		logic [7:0]  want;
		int unsigned n;
		for (int d = 0; d < 8; d++) begin
			n = 0;
			while (seg_choice !== ~(8'h01 << d)) begin
				if (n == 16 * scan_div) fail_timeout("seg_choice to select the next digit");
				@(negedge sys_clk);
				n++;
			end
			case (d)
				7: want = board_pkg::seg_font[4'hf];
				4: want = board_pkg::seg_font[tx[7:4]];
				3: want = board_pkg::seg_font[tx[3:0]];
				1: want = board_pkg::seg_font[rx[7:4]];
				0: want = board_pkg::seg_font[rx[3:0]];
				default: want = board_pkg::seg_blank;
			endcase
			check_value("seg_number", 32'(seg_number), 32'(want));
		end
	endtask

	// expected tx is the ascii digit of the key and expected led the last byte sent
	task automatic build_table();
		logic [1:0] acts [0:row_count-1];
		logic [1:0] keys [0:row_count-1];
		logic [7:0] last_tx;
		logic [7:0] last_rx;
		acts = '{act_press, act_press, act_bounce, act_press, act_send,
			act_press, act_send, act_send, act_press};
		keys = '{2'd0, 2'd1, 2'd2, 2'd2, 2'd0, 2'd3, 2'd0, 2'd0, 2'd1};
		last_tx = 8'h00;
		last_rx = 8'h00;
		for (int r = 0; r < row_count; r++) begin
			rows[r].act      = acts[r];
			rows[r].key      = keys[r];
			rows[r].data     = 8'h00;
			rows[r].exp_beep = 1'b0;
			if (acts[r] == act_press) begin
				last_tx          = 8'h30 + {6'd0, keys[r]};
				rows[r].exp_beep = 1'b1;
			end else if (acts[r] == act_send) begin
				rows[r].data = 8'($urandom());
				last_rx      = rows[r].data;
			end
			rows[r].exp_tx  = last_tx;
			rows[r].exp_led = last_rx;
		end
	endtask

	initial begin
		sys_clk      = 1'b0;
		sys_rst_n    = 1'b0;
		key_in       = '1;
		uart_rx_port = 1'b1;
		void'($urandom(85670));
		build_table();
		repeat (5) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		for (int r = 0; r < row_count; r++) begin
			case (rows[r].act)
				act_press: press_key(rows[r].key, rows[r].exp_tx, rows[r].exp_beep);
				act_bounce: bounce_key(rows[r].key);
				default: begin
					send_byte(rows[r].data);
					wait_led(rows[r].data);
				end
			endcase
			check_value("led", 32'(led), 32'(rows[r].exp_led));
		end
		check_scan(rows[row_count-1].exp_tx, rows[row_count-1].exp_led);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire
